//--- include/memTest_consts.svh
`ifndef MEMTEST_CONSTS_SVH
`define MEMTEST_CONSTS_SVH

// --------------------------------------------------
// data path widths
// --------------------------------------------------
`define MEM_WORD_BITS 16
`define MEM_ADDR_BITS 25
// store only decodes the low address bits
`define STORE_DEPTH_BITS 10

// --------------------------------------------------
// startup loader
// --------------------------------------------------
`define LOAD_WORDS 10
`define LOAD_INDEX_BITS 4
`define LOAD_BASE_ADDR 128
`define LOAD_DATA_BASE 100
// wait before and after the idle check
`define LOAD_SETTLE_CYCLES 10
`define SETTLE_COUNT_BITS 8

// --------------------------------------------------
// pattern tester
// --------------------------------------------------
`define TEST_WORDS 64
`define TEST_INDEX_BITS 7
`define TEST_BASE_ADDR 256
// data word is ~addr[15:0] ^ this value
`define TEST_PATTERN 16'hA5A5

// --------------------------------------------------
// controller busy lengths, in clock cycles
// --------------------------------------------------
`define WRITE_BUSY_CYCLES 4
`define READ_BUSY_CYCLES 6
`define BUSY_COUNT_BITS 4

`endif

//--- rtl/memTestPkg.sv
`include "memTest_consts.svh"

package memTestPkg;

	// one data word and one request address
	typedef logic [`MEM_WORD_BITS-1:0] memWord_t;
	typedef logic [`MEM_ADDR_BITS-1:0] memAddr_t;

	// request operation
	typedef enum logic {
		opWrite,
		opRead
	} memOp_e;

	// startup loader sequence
	typedef enum logic [3:0] {
		ldSettle,
		ldWaitIdle,
		ldSettleAfter,
		ldWriteIssue,
		ldWriteWait,
		ldPause,
		ldReadIssue,
		ldReadWait,
		ldDone
	} loaderState_e;

	// pattern tester sequence
	typedef enum logic [2:0] {
		tsIdle,
		tsWriteIssue,
		tsWriteWait,
		tsReadIssue,
		tsReadWait,
		tsPassed,
		tsFailed
	} testerState_e;

	// who drives the memory port
	typedef enum logic {
		ownerLoader,
		ownerTester
	} ownerSel_e;

endpackage

//--- rtl/memoryController.sv
`timescale 1ns/1ps
`include "memTest_consts.svh"

module memoryController (
	input  logic                 clock143Mhz,
	input  logic                 reset_n,
	input  logic                 inputValid,
	input  memTestPkg::memOp_e   operation,
	input  memTestPkg::memAddr_t address,
	input  memTestPkg::memWord_t inputData,
	output logic                 recievedCommand,
	output logic                 isBusy,
	output logic                 outputValid,
	output memTestPkg::memWord_t outputData
);

	localparam int storeWords = 2 ** `STORE_DEPTH_BITS;

	// word store plus a per-word written flag
	memTestPkg::memWord_t wordStore [storeWords];
	logic [storeWords-1:0] writtenFlags;

	logic [`STORE_DEPTH_BITS-1:0] storeIndex;
	logic [`STORE_DEPTH_BITS-1:0] pendingIndex;
	logic [`BUSY_COUNT_BITS-1:0] busyCount;
	logic pendingRead;
	logic accept;

	// only the low address bits select a word
	assign storeIndex = address[`STORE_DEPTH_BITS-1:0];

	// one request at a time
	assign accept = inputValid && !isBusy;

	// --------------------------------------------------
	// storage and read return path
	// --------------------------------------------------
	always_ff @(posedge clock143Mhz) begin
		if (accept) begin
			pendingIndex <= storeIndex;
			if (operation == memTestPkg::opWrite) begin
				wordStore[storeIndex] <= inputData;
			end
		end
		// fetch one cycle ahead so data lines up with outputValid
		if (isBusy && pendingRead && busyCount == `BUSY_COUNT_BITS'(1)) begin
			outputData <= writtenFlags[pendingIndex] ? wordStore[pendingIndex] : '0;
		end
	end

	// --------------------------------------------------
	// strobes and busy countdown
	// --------------------------------------------------
	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			recievedCommand <= 1'b0;
			isBusy <= 1'b0;
			outputValid <= 1'b0;
			busyCount <= '0;
			pendingRead <= 1'b0;
			writtenFlags <= '0;
		end
		else begin
			// acknowledge lands together with busy rising
			recievedCommand <= accept;
			outputValid <= 1'b0;
			if (accept) begin
				isBusy <= 1'b1;
				pendingRead <= (operation == memTestPkg::opRead);
				if (operation == memTestPkg::opRead) begin
					busyCount <= `BUSY_COUNT_BITS'(`READ_BUSY_CYCLES - 1);
				end
				else begin
					busyCount <= `BUSY_COUNT_BITS'(`WRITE_BUSY_CYCLES - 1);
					writtenFlags[storeIndex] <= 1'b1;
				end
			end
			else if (isBusy) begin
				// last busy cycle reached, drop busy next
				if (busyCount == '0) begin
					isBusy <= 1'b0;
				end
				else begin
					busyCount <= busyCount - 1'b1;
				end
				// read data shows in the final busy cycle
				if (pendingRead && busyCount == `BUSY_COUNT_BITS'(1)) begin
					outputValid <= 1'b1;
				end
			end
		end
	end

endmodule

//--- rtl/busArbiter.sv
`timescale 1ns/1ps

module busArbiter (
	input  logic                 clock143Mhz,
	input  logic                 reset_n,
	input  logic                 loaderValid,
	input  memTestPkg::memOp_e   loaderOp,
	input  memTestPkg::memAddr_t loaderAddress,
	input  memTestPkg::memWord_t loaderData,
	input  logic                 loadDone,
	input  logic                 testerValid,
	input  memTestPkg::memOp_e   testerOp,
	input  memTestPkg::memAddr_t testerAddress,
	input  memTestPkg::memWord_t testerData,
	input  logic                 memBusy,
	input  logic                 memReceived,
	input  logic                 memValid,
	input  memTestPkg::memWord_t memData,
	output logic                 memRequestValid,
	output memTestPkg::memOp_e   memOp,
	output memTestPkg::memAddr_t memAddress,
	output memTestPkg::memWord_t memWriteData,
	output logic                 loaderBusy,
	output logic                 loaderReceived,
	output logic                 loaderReadValid,
	output logic                 testerGranted,
	output logic                 testerBusy,
	output logic                 testerReceived,
	output logic                 testerReadValid,
	output memTestPkg::memWord_t readData
);

	memTestPkg::ownerSel_e owner;
	logic loaderOwns;

	// loader first, tester once it is done and the port is quiet
	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			owner <= memTestPkg::ownerLoader;
		end
		else if (loadDone && !memBusy) begin
			// one-way handover, never returns
			owner <= memTestPkg::ownerTester;
		end
	end

	assign loaderOwns = (owner == memTestPkg::ownerLoader);
	assign testerGranted = !loaderOwns;

	// forward only the owner's request
	assign memRequestValid = loaderOwns ? loaderValid : testerValid;
	assign memOp = loaderOwns ? loaderOp : testerOp;
	assign memAddress = loaderOwns ? loaderAddress : testerAddress;
	assign memWriteData = loaderOwns ? loaderData : testerData;

	// non-owner sees a permanently busy port
	assign loaderBusy = loaderOwns ? memBusy : 1'b1;
	assign testerBusy = loaderOwns ? 1'b1 : memBusy;

	// strobes go to the owner only
	assign loaderReceived = loaderOwns && memReceived;
	assign loaderReadValid = loaderOwns && memValid;
	assign testerReceived = !loaderOwns && memReceived;
	assign testerReadValid = !loaderOwns && memValid;
	// data is meaningless without a strobe, so it can be shared
	assign readData = memData;

endmodule

//--- rtl/startupLoader.sv
`timescale 1ns/1ps
`include "memTest_consts.svh"

module startupLoader (
	input  logic                        clock143Mhz,
	input  logic                        reset_n,
	input  logic                        readStart,
	input  logic                        memBusy,
	input  logic                        memReceived,
	input  logic                        memReadValid,
	input  memTestPkg::memWord_t        readData,
	output logic                        requestValid,
	output memTestPkg::memOp_e          requestOp,
	output memTestPkg::memAddr_t        requestAddress,
	output memTestPkg::memWord_t        requestData,
	output logic                        awaitingRead,
	output logic                        loadDone,
	input  logic [`LOAD_INDEX_BITS-1:0] wordSelect,
	input  logic                        showWritten,
	output memTestPkg::memWord_t        displayWord
);

	localparam memTestPkg::memAddr_t baseAddress = `LOAD_BASE_ADDR;
	localparam memTestPkg::memWord_t dataBase = `LOAD_DATA_BASE;

	memTestPkg::loaderState_e state;
	logic [`SETTLE_COUNT_BITS-1:0] settleCount;
	logic [`LOAD_INDEX_BITS-1:0] wordIndex;
	logic lastWord;
	logic settled;

	// kept values for the display
	memTestPkg::memWord_t writtenWords [`LOAD_WORDS];
	memTestPkg::memWord_t readWords [`LOAD_WORDS];

	assign lastWord = (wordIndex == `LOAD_INDEX_BITS'(`LOAD_WORDS - 1));
	assign settled = (settleCount == `SETTLE_COUNT_BITS'(`LOAD_SETTLE_CYCLES));

	// --------------------------------------------------
	// request drive, steady for the whole issue state
	// --------------------------------------------------
	assign requestValid = (state == memTestPkg::ldWriteIssue) ||
		(state == memTestPkg::ldReadIssue);
	assign requestOp = (state == memTestPkg::ldWriteIssue) ?
		memTestPkg::opWrite : memTestPkg::opRead;
	// word i at base+i, value 100+i
	assign requestAddress = baseAddress + memTestPkg::memAddr_t'(wordIndex);
	assign requestData = dataBase + memTestPkg::memWord_t'(wordIndex);

	assign awaitingRead = (state == memTestPkg::ldPause);
	assign loadDone = (state == memTestPkg::ldDone);

	// --------------------------------------------------
	// sequence
	// --------------------------------------------------
	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			state <= memTestPkg::ldSettle;
			settleCount <= '0;
			wordIndex <= '0;
		end
		else begin
			case (state)
				// first settling wait
				memTestPkg::ldSettle: begin
					if (settled) begin
						settleCount <= '0;
						state <= memTestPkg::ldWaitIdle;
					end
					else begin
						settleCount <= settleCount + 1'b1;
					end
				end
				memTestPkg::ldWaitIdle: begin
					if (!memBusy) begin
						state <= memTestPkg::ldSettleAfter;
					end
				end
				// second wait, then start writing
				memTestPkg::ldSettleAfter: begin
					if (settled) begin
						wordIndex <= '0;
						state <= memTestPkg::ldWriteIssue;
					end
					else begin
						settleCount <= settleCount + 1'b1;
					end
				end
				memTestPkg::ldWriteIssue: begin
					if (memReceived) begin
						state <= memTestPkg::ldWriteWait;
					end
				end
				// busy is already up with the acknowledge
				memTestPkg::ldWriteWait: begin
					if (!memBusy) begin
						if (lastWord) begin
							wordIndex <= '0;
							state <= memTestPkg::ldPause;
						end
						else begin
							wordIndex <= wordIndex + 1'b1;
							state <= memTestPkg::ldWriteIssue;
						end
					end
				end
				// hold here until told to read back
				memTestPkg::ldPause: begin
					if (readStart) begin
						state <= memTestPkg::ldReadIssue;
					end
				end
				memTestPkg::ldReadIssue: begin
					if (memReceived) begin
						state <= memTestPkg::ldReadWait;
					end
				end
				memTestPkg::ldReadWait: begin
					if (!memBusy) begin
						if (lastWord) begin
							state <= memTestPkg::ldDone;
						end
						else begin
							wordIndex <= wordIndex + 1'b1;
							state <= memTestPkg::ldReadIssue;
						end
					end
				end
				memTestPkg::ldDone: begin
					state <= memTestPkg::ldDone;
				end
				default: begin
					state <= memTestPkg::ldSettle;
				end
			endcase
		end
	end

	// --------------------------------------------------
	// kept words
	// --------------------------------------------------
	always_ff @(posedge clock143Mhz) begin
		// written value once the controller took it
		if (state == memTestPkg::ldWriteIssue && memReceived) begin
			writtenWords[wordIndex] <= requestData;
		end
		// read value as it arrives
		if (state == memTestPkg::ldReadWait && memReadValid) begin
			readWords[wordIndex] <= readData;
		end
	end

	// display select, zero until done or when out of range
	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			displayWord <= '0;
		end
		else if (loadDone && wordSelect < `LOAD_INDEX_BITS'(`LOAD_WORDS)) begin
			displayWord <= showWritten ? writtenWords[wordSelect] : readWords[wordSelect];
		end
		else begin
			displayWord <= '0;
		end
	end

endmodule

//--- rtl/patternTester.sv
`timescale 1ns/1ps
`include "memTest_consts.svh"

module patternTester (
	input  logic                 clock143Mhz,
	input  logic                 reset_n,
	input  logic                 granted,
	input  logic                 memBusy,
	input  logic                 memReceived,
	input  logic                 memReadValid,
	input  memTestPkg::memWord_t readData,
	output logic                 requestValid,
	output memTestPkg::memOp_e   requestOp,
	output memTestPkg::memAddr_t requestAddress,
	output memTestPkg::memWord_t requestData,
	output logic                 completedSuccess,
	output logic                 compareError
);

	localparam memTestPkg::memAddr_t baseAddress = `TEST_BASE_ADDR;

	memTestPkg::testerState_e state;
	logic [`TEST_INDEX_BITS-1:0] wordIndex;
	logic lastWord;

	// pattern word derived from the address alone
	function automatic memTestPkg::memWord_t patternFor(input memTestPkg::memAddr_t addr);
		return ~addr[`MEM_WORD_BITS-1:0] ^ `TEST_PATTERN;
	endfunction

	assign lastWord = (wordIndex == `TEST_INDEX_BITS'(`TEST_WORDS - 1));

	// request fields follow state and index
	assign requestValid = (state == memTestPkg::tsWriteIssue) ||
		(state == memTestPkg::tsReadIssue);
	assign requestOp = (state == memTestPkg::tsWriteIssue) ?
		memTestPkg::opWrite : memTestPkg::opRead;
	assign requestAddress = baseAddress + memTestPkg::memAddr_t'(wordIndex);
	assign requestData = patternFor(requestAddress);

	// sticky result flags
	assign completedSuccess = (state == memTestPkg::tsPassed);
	assign compareError = (state == memTestPkg::tsFailed);

	// --------------------------------------------------
	// write pass, then read and compare pass
	// --------------------------------------------------
	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			state <= memTestPkg::tsIdle;
			wordIndex <= '0;
		end
		else begin
			case (state)
				// nothing until the port is ours
				memTestPkg::tsIdle: begin
					if (granted) begin
						wordIndex <= '0;
						state <= memTestPkg::tsWriteIssue;
					end
				end
				memTestPkg::tsWriteIssue: begin
					if (memReceived) begin
						state <= memTestPkg::tsWriteWait;
					end
				end
				memTestPkg::tsWriteWait: begin
					if (!memBusy) begin
						// restart at the base for the read pass
						if (lastWord) begin
							wordIndex <= '0;
							state <= memTestPkg::tsReadIssue;
						end
						else begin
							wordIndex <= wordIndex + 1'b1;
							state <= memTestPkg::tsWriteIssue;
						end
					end
				end
				memTestPkg::tsReadIssue: begin
					if (memReceived) begin
						state <= memTestPkg::tsReadWait;
					end
				end
				memTestPkg::tsReadWait: begin
					// data comes in the last busy cycle
					if (memReadValid && readData != patternFor(requestAddress)) begin
						state <= memTestPkg::tsFailed;
					end
					else if (!memBusy) begin
						if (lastWord) begin
							state <= memTestPkg::tsPassed;
						end
						else begin
							wordIndex <= wordIndex + 1'b1;
							state <= memTestPkg::tsReadIssue;
						end
					end
				end
				memTestPkg::tsPassed: begin
					state <= memTestPkg::tsPassed;
				end
				memTestPkg::tsFailed: begin
					state <= memTestPkg::tsFailed;
				end
				default: begin
					state <= memTestPkg::tsIdle;
				end
			endcase
		end
	end

endmodule

//--- rtl/memTestTop.sv
`timescale 1ns/1ps
`include "memTest_consts.svh"

module memTestTop (
	input  logic                        clock143Mhz,
	input  logic                        reset_n,
	input  logic                        readStart,
	input  logic [`LOAD_INDEX_BITS-1:0] wordSelect,
	input  logic                        showWritten,
	output logic                        awaitingRead,
	output logic                        loadDone,
	output logic                        memBusy,
	output logic                        completedSuccess,
	output logic                        compareError,
	output memTestPkg::memWord_t        displayWord
);

	// --------------------------------------------------
	// loader side
	// --------------------------------------------------
	logic loaderValid;
	memTestPkg::memOp_e loaderOp;
	memTestPkg::memAddr_t loaderAddress;
	memTestPkg::memWord_t loaderData;
	logic loaderBusy;
	logic loaderReceived;
	logic loaderReadValid;

	// --------------------------------------------------
	// tester side
	// --------------------------------------------------
	logic testerValid;
	memTestPkg::memOp_e testerOp;
	memTestPkg::memAddr_t testerAddress;
	memTestPkg::memWord_t testerData;
	logic testerGranted;
	logic testerBusy;
	logic testerReceived;
	logic testerReadValid;

	// shared controller port
	logic memRequestValid;
	memTestPkg::memOp_e memOp;
	memTestPkg::memAddr_t memAddress;
	memTestPkg::memWord_t memWriteData;
	logic memReceived;
	logic memValid;
	memTestPkg::memWord_t memData;
	// returned word, fanned out to both peers
	memTestPkg::memWord_t readData;

	startupLoader startupLoader_inst (
		.clock143Mhz(clock143Mhz),
		.reset_n(reset_n),
		.readStart(readStart),
		.memBusy(loaderBusy),
		.memReceived(loaderReceived),
		.memReadValid(loaderReadValid),
		.readData(readData),
		.requestValid(loaderValid),
		.requestOp(loaderOp),
		.requestAddress(loaderAddress),
		.requestData(loaderData),
		.awaitingRead(awaitingRead),
		.loadDone(loadDone),
		.wordSelect(wordSelect),
		.showWritten(showWritten),
		.displayWord(displayWord)
	);

	patternTester patternTester_inst (
		.clock143Mhz(clock143Mhz),
		.reset_n(reset_n),
		.granted(testerGranted),
		.memBusy(testerBusy),
		.memReceived(testerReceived),
		.memReadValid(testerReadValid),
		.readData(readData),
		.requestValid(testerValid),
		.requestOp(testerOp),
		.requestAddress(testerAddress),
		.requestData(testerData),
		.completedSuccess(completedSuccess),
		.compareError(compareError)
	);

	busArbiter busArbiter_inst (
		.clock143Mhz(clock143Mhz),
		.reset_n(reset_n),
		.loaderValid(loaderValid),
		.loaderOp(loaderOp),
		.loaderAddress(loaderAddress),
		.loaderData(loaderData),
		.loadDone(loadDone),
		.testerValid(testerValid),
		.testerOp(testerOp),
		.testerAddress(testerAddress),
		.testerData(testerData),
		.memBusy(memBusy),
		.memReceived(memReceived),
		.memValid(memValid),
		.memData(memData),
		.memRequestValid(memRequestValid),
		.memOp(memOp),
		.memAddress(memAddress),
		.memWriteData(memWriteData),
		.loaderBusy(loaderBusy),
		.loaderReceived(loaderReceived),
		.loaderReadValid(loaderReadValid),
		.testerGranted(testerGranted),
		.testerBusy(testerBusy),
		.testerReceived(testerReceived),
		.testerReadValid(testerReadValid),
		.readData(readData)
	);

	memoryController memoryController_inst (
		.clock143Mhz(clock143Mhz),
		.reset_n(reset_n),
		.inputValid(memRequestValid),
		.operation(memOp),
		.address(memAddress),
		.inputData(memWriteData),
		.recievedCommand(memReceived),
		.isBusy(memBusy),
		.outputValid(memValid),
		.outputData(memData)
	);

endmodule

//--- verif/memTestTop_assertions.sv
`timescale 1ns/1ps

module memTestTop_assertions (
	input logic                 clock143Mhz,
	input logic                 reset_n,
	input logic                 memRequestValid,
	input memTestPkg::memOp_e   memOp,
	input memTestPkg::memAddr_t memAddress,
	input logic                 memReceived,
	input logic                 memBusy,
	input logic                 memValid,
	input logic                 loaderValid,
	input logic                 testerValid
);

	logic accept;
	logic readInFlight;
	// count of broken port rules
	int portErrors = 0;

	assign accept = memRequestValid && !memBusy;

	// remember the kind of the last accepted request
	always_ff @(posedge clock143Mhz) begin
		if (!reset_n) begin
			readInFlight <= 1'b0;
		end
		else if (accept) begin
			readInFlight <= (memOp == memTestPkg::opRead);
		end
	end

	// --------------------------------------------------
	// port rules
	// --------------------------------------------------
	ackAfterAccept: assert property (@(posedge clock143Mhz) disable iff (!reset_n)
		accept |=> memReceived)
		else begin
			$error("recievedCommand missing after an accepted request");
			portErrors++;
		end

	ackOnlyAfterAccept: assert property (@(posedge clock143Mhz) disable iff (!reset_n)
		memReceived |-> $past(accept))
		else begin
			$error("recievedCommand without a preceding accepted request");
			portErrors++;
		end

	// read data only inside a read's busy window
	readValidInRead: assert property (@(posedge clock143Mhz) disable iff (!reset_n)
		memValid |-> (memBusy && readInFlight))
		else begin
			$error("outputValid outside a read busy window");
			portErrors++;
		end

	requestHeld: assert property (@(posedge clock143Mhz) disable iff (!reset_n)
		(memRequestValid && !memReceived) |=> (memRequestValid && $stable(memAddress)))
		else begin
			$error("request dropped or address changed before recievedCommand");
			portErrors++;
		end

	singleRequester: assert property (@(posedge clock143Mhz) disable iff (!reset_n)
		!(loaderValid && testerValid))
		else begin
			$error("loader and tester requesting in the same cycle");
			portErrors++;
		end

endmodule

//--- verif/memTestTop_tb.sv
`timescale 1ns/1ps
`include "memTest_consts.svh"

module memTestTop_tb;

	localparam int clockPeriod = 100;
	localparam int driveDelay = 1;
	localparam int resetCycles = 10;
	// cycles the final flags must hold
	localparam int stableCycles = 20;
	localparam int stimulusDepth = 128;

	logic clock143Mhz;
	logic reset_n;
	logic readStart;
	logic [`LOAD_INDEX_BITS-1:0] wordSelect;
	logic showWritten;
	logic awaitingRead;
	logic loadDone;
	logic memBusy;
	logic completedSuccess;
	logic compareError;
	memTestPkg::memWord_t displayWord;

	// pause, row count, rows of three, then the two flags
	logic [15:0] stimulus [stimulusDepth];
	int pauseCycles;
	int rowCount;
	int flagIndex;
	int row;
	logic expectSuccess;
	logic expectError;
	int watchdogCycles = 0;

	memTestTop memTestTop_inst (
		.clock143Mhz(clock143Mhz),
		.reset_n(reset_n),
		.readStart(readStart),
		.wordSelect(wordSelect),
		.showWritten(showWritten),
		.awaitingRead(awaitingRead),
		.loadDone(loadDone),
		.memBusy(memBusy),
		.completedSuccess(completedSuccess),
		.compareError(compareError),
		.displayWord(displayWord)
	);

	// port checks on the shared controller port
	bind memTestTop memTestTop_assertions memTestTop_assertions_inst (
		.clock143Mhz(clock143Mhz),
		.reset_n(reset_n),
		.memRequestValid(memRequestValid),
		.memOp(memOp),
		.memAddress(memAddress),
		.memReceived(memReceived),
		.memBusy(memBusy),
		.memValid(memValid),
		.loaderValid(loaderValid),
		.testerValid(testerValid)
	);

	initial begin
		clock143Mhz = 1'b0;
		forever #(clockPeriod / 2) clock143Mhz = ~clock143Mhz;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic stopWithFailure(input string line);
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	// inputs change just after the rising edge
	task automatic waitDriveSlot();
		@(posedge clock143Mhz);
		#driveDelay;
	endtask

	task automatic expectIdleOutputs(input string when);
		assert (awaitingRead === 1'b0 && loadDone === 1'b0 && completedSuccess === 1'b0 &&
			compareError === 1'b0 && memBusy === 1'b0)
		else stopWithFailure($sformatf(
			"FAIL at %0t: outputs not low %s (await=%b done=%b ok=%b err=%b busy=%b)",
			$time, when, awaitingRead, loadDone, completedSuccess, compareError, memBusy));
	endtask

	task automatic checkReset();
		int cycle;
		for (cycle = 1; cycle < resetCycles; cycle++) begin
			@(negedge clock143Mhz);
			expectIdleOutputs("during reset");
		end
		// release after the tenth sampled edge
		waitDriveSlot();
		reset_n = 1'b1;
		@(posedge clock143Mhz);
		@(negedge clock143Mhz);
		expectIdleOutputs("after reset release");
	endtask

	// hold readStart low and watch the pause level
	task automatic checkPause();
		int cycle;
		while (awaitingRead !== 1'b1) @(negedge clock143Mhz);
		for (cycle = 0; cycle < pauseCycles; cycle++) begin
			@(negedge clock143Mhz);
			assert (awaitingRead === 1'b1 && loadDone === 1'b0)
			else stopWithFailure($sformatf(
				"FAIL at %0t: pause not held in cycle %0d (await=%b done=%b)",
				$time, cycle, awaitingRead, loadDone));
		end
		waitDriveSlot();
		readStart = 1'b1;
		// readback runs until loadDone
		while (loadDone !== 1'b1) @(negedge clock143Mhz);
		waitDriveSlot();
		readStart = 1'b0;
	endtask

	task automatic checkDisplayRow(input int index);
		logic [`LOAD_INDEX_BITS-1:0] select;
		logic written;
		memTestPkg::memWord_t expected;
		select = stimulus[2 + 3 * index][`LOAD_INDEX_BITS-1:0];
		written = stimulus[3 + 3 * index][0];
		expected = stimulus[4 + 3 * index];
		waitDriveSlot();
		wordSelect = select;
		showWritten = written;
		// registered, so look after the next edge
		@(posedge clock143Mhz);
		@(negedge clock143Mhz);
		assert (displayWord === expected && loadDone === 1'b1)
		else stopWithFailure($sformatf(
			"FAIL at %0t: select %0d written=%b shows %h, expected %h (done=%b)",
			$time, select, written, displayWord, expected, loadDone));
	endtask

	task automatic checkTesterResult();
		int cycle;
		while (completedSuccess !== 1'b1 && compareError !== 1'b1) @(negedge clock143Mhz);
		for (cycle = 0; cycle < stableCycles; cycle++) begin
			assert (completedSuccess === expectSuccess && compareError === expectError)
			else stopWithFailure($sformatf(
				"FAIL at %0t: tester flags ok=%b err=%b, expected ok=%b err=%b",
				$time, completedSuccess, compareError, expectSuccess, expectError));
			@(negedge clock143Mhz);
		end
	endtask

	// a broken port rule in the bound checker ends the run at once
	always @(negedge clock143Mhz) begin
		assert (memTestTop_inst.memTestTop_assertions_inst.portErrors == 0)
		else stopWithFailure("a bound memory port assertion failed");
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		reset_n = 1'b0;
		readStart = 1'b0;
		wordSelect = '0;
		showWritten = 1'b0;
		$readmemh("verif/memTestTop_stimulus.txt", stimulus);
		pauseCycles = stimulus[0];
		rowCount = stimulus[1];
		flagIndex = 2 + 3 * rowCount;
		expectSuccess = stimulus[flagIndex][0];
		expectError = stimulus[flagIndex + 1][0];
		// settle, loader traffic, pause, rows, tester traffic, plus margin
		watchdogCycles = resetCycles + 2 * (`LOAD_SETTLE_CYCLES + 2)
			+ `LOAD_WORDS * (`WRITE_BUSY_CYCLES + `READ_BUSY_CYCLES + 8)
			+ pauseCycles + 3 * rowCount
			+ `TEST_WORDS * (`WRITE_BUSY_CYCLES + `READ_BUSY_CYCLES + 8)
			+ stableCycles + 200;
		checkReset();
		checkPause();
		for (row = 0; row < rowCount; row++) begin
			checkDisplayRow(row);
		end
		checkTesterResult();
		if (memTestTop_inst.memTestTop_assertions_inst.portErrors == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else begin
			stopWithFailure("a bound memory port assertion failed");
		end
	end

	// watchdog
	initial begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge clock143Mhz);
		stopWithFailure($sformatf("timeout: the run hung, no result after %0d clock cycles",
			watchdogCycles));
	end

endmodule

//--- verif/memTestTop_stimulus.txt
// hex: pause cycles, row count, then rows of wordSelect showWritten expected displayWord
// last line: expected completedSuccess compareError
14
17
0 1 0064
1 1 0065
2 1 0066
3 1 0067
4 1 0068
5 1 0069
6 1 006A
7 1 006B
8 1 006C
9 1 006D
0 0 0064
1 0 0065
2 0 0066
3 0 0067
4 0 0068
5 0 0069
6 0 006A
7 0 006B
8 0 006C
9 0 006D
A 1 0000
C 0 0000
F 1 0000
1 0

//--- memTestTop.f
+incdir+include
rtl/memTestPkg.sv
rtl/memoryController.sv
rtl/busArbiter.sv
rtl/startupLoader.sv
rtl/patternTester.sv
rtl/memTestTop.sv
verif/memTestTop_assertions.sv
verif/memTestTop_tb.sv
